/* Makefile */
# Verilator build for the front-panel UI testbench

VERILATOR ?= verilator
TOP       ?= instr_ui_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=
PASS_LINE ?= >>> PASS

COMMON = --timing --assert --top-module $(TOP) -f $(FILELIST) $(VFLAGS)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(COMMON)

sim:
	$(VERILATOR) --binary -Mdir $(OBJ_DIR) $(COMMON)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx '$(PASS_LINE)' $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/instr_params.svh */
`ifndef instr_params_svh
`define instr_params_svh

// front panel keys, all active low
`define key_count 6
`define key_hold_cycles 1000

// top menu and signal-generator panel
`define menu_items 3
`define sig_field_count 5
`define setting_max 3

// oscilloscope zoom steps run 0..zoom_max
`define zoom_max 2

// logic-analyzer reference marker, in pixels
`define marker_step 80
`define marker_max 1440
`define marker_w 12

`endif

/* hw/instr_pkg.sv */
`include "instr_params.svh"

package instr_pkg;

    // which screen owns the keys
    typedef enum logic [1:0] {
        mode_menu,
        mode_sig,
        mode_osc,
        mode_la
    } instr_mode_t;

    // field cursor of the signal-generator panel
    typedef enum logic [2:0] {
        field_wave,
        field_amp,
        field_freq,
        field_phase,
        field_apply
    } sig_field_t;

    // one-cycle release pulses, one per key
    typedef struct packed {
        logic left;
        logic right;
        logic up;
        logic down;
        logic confirm;
        logic quit;
    } key_events_t;

    typedef struct packed {
        sig_field_t field;
        logic [1:0] wave;
        logic [1:0] amp;
        logic [1:0] freq;
        logic [1:0] phase;
        logic       applied;
    } sig_settings_t;

    typedef struct packed {
        logic [1:0] v_zoom;
        logic [1:0] h_zoom;
        logic       fft_run;
    } osc_settings_t;

    typedef struct packed {
        logic [`marker_w-1:0] marker;
        logic                 paused;
        logic                 scroll_left;
        logic                 scroll_right;
    } la_settings_t;

endpackage

/* hw/instr_ui_top.sv */
`timescale 1ns/1ps
`include "instr_params.svh"

module instr_ui_top import instr_pkg::*; #(
    parameter int hold_cycles = `key_hold_cycles
) (
    input  logic                  clk_50M,
    input  logic                  rst_n,
    input  logic [`key_count-1:0] key_in,
    output instr_mode_t           mode,
    output logic [1:0]            menu_cursor,
    output sig_settings_t         sig_settings,
    output osc_settings_t         osc_settings,
    output la_settings_t          la_settings,
    output logic                  la_capture_run
);
    logic [`key_count-1:0] release_evt;
    key_events_t           keys;

    for (genvar i = 0; i < `key_count; i++) begin : g_key
        key_debounce #(
            .hold_cycles(hold_cycles)
        ) u_key_debounce (
            .clk_50M      (clk_50M),
            .rst_n        (rst_n),
            .key_raw      (key_in[i]),
            .key_level    (),
            .release_pulse(release_evt[i])
        );
    end

    // key_in order is left, right, up, down, confirm, quit from bit 0
    assign keys = '{
        left:    release_evt[0],
        right:   release_evt[1],
        up:      release_evt[2],
        down:    release_evt[3],
        confirm: release_evt[4],
        quit:    release_evt[5]
    };

    menu_ctrl u_menu_ctrl (
        .clk_50M    (clk_50M),
        .rst_n      (rst_n),
        .keys       (keys),
        .mode       (mode),
        .menu_cursor(menu_cursor)
    );

    sig_panel u_sig_panel (
        .clk_50M (clk_50M),
        .rst_n   (rst_n),
        .keys    (keys),
        .mode    (mode),
        .settings(sig_settings)
    );

    osc_panel u_osc_panel (
        .clk_50M (clk_50M),
        .rst_n   (rst_n),
        .keys    (keys),
        .mode    (mode),
        .settings(osc_settings)
    );

    la_panel u_la_panel (
        .clk_50M    (clk_50M),
        .rst_n      (rst_n),
        .keys       (keys),
        .mode       (mode),
        .settings   (la_settings),
        .capture_run(la_capture_run)
    );

endmodule

/* hw/key_debounce.sv */
`timescale 1ns/1ps
`include "instr_params.svh"

module key_debounce #(
    parameter int hold_cycles = `key_hold_cycles
) (
    input  logic clk_50M,
    input  logic rst_n,
    input  logic key_raw,
    output logic key_level,
    output logic release_pulse
);
    localparam int cnt_w = $clog2(hold_cycles + 1);

    logic [1:0]       sync_q;
    logic [cnt_w-1:0] hold_cnt;
    logic             key_sync;
    logic             differs;
    logic             flip;

    assign key_sync = sync_q[1];
    assign differs  = key_sync != key_level;
    assign flip     = differs && (hold_cnt == cnt_w'(hold_cycles - 1));

    // raw key comes straight from the pin
    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            sync_q <= 2'b11;
        end else begin
            sync_q <= {sync_q[0], key_raw};
        end
    end

    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            hold_cnt      <= '0;
            key_level     <= 1'b1;
            release_pulse <= 1'b0;
        end else begin
            release_pulse <= 1'b0;
            if (!differs) begin
                hold_cnt <= '0;
            end else if (flip) begin
                hold_cnt      <= '0;
                key_level     <= key_sync;
                // low to high is a release
                release_pulse <= key_sync;
            end else begin
                hold_cnt <= hold_cnt + 1'b1;
            end
        end
    end

endmodule

/* hw/la_panel.sv */
`timescale 1ns/1ps
`include "instr_params.svh"

module la_panel import instr_pkg::*; (
    input  logic         clk_50M,
    input  logic         rst_n,
    input  key_events_t  keys,
    input  instr_mode_t  mode,
    output la_settings_t settings,
    output logic         capture_run
);
    localparam int             mw           = `marker_w;
    localparam logic [mw-1:0] marker_first = mw'(`marker_step);
    localparam logic [mw-1:0] marker_last  = mw'(`marker_max);

    logic in_la;
    logic active;

    assign in_la  = mode == mode_la;
    assign active = in_la && !keys.quit;

    always_ff @(posedge clk_50M) begin
        if (!rst_n || !active) begin
            settings.marker       <= marker_first;
            settings.paused       <= 1'b0;
            settings.scroll_left  <= 1'b0;
            settings.scroll_right <= 1'b0;
        end else begin
            if (keys.confirm) begin
                settings.paused <= !settings.paused;
            end

            // scroll only while the trace is held
            settings.scroll_left  <= settings.paused && keys.up;
            settings.scroll_right <= settings.paused && keys.down;

            if (keys.left) begin
                if (settings.marker <= marker_first) begin
                    settings.marker <= marker_last;
                end else begin
                    settings.marker <= settings.marker - marker_first;
                end
            end else if (keys.right) begin
                if (settings.marker >= marker_last) begin
                    settings.marker <= marker_first;
                end else begin
                    settings.marker <= settings.marker + marker_first;
                end
            end
        end
    end

    // capture follows the mode one cycle late
    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            capture_run <= 1'b0;
        end else begin
            capture_run <= in_la;
        end
    end

endmodule

/* hw/menu_ctrl.sv */
`timescale 1ns/1ps
`include "instr_params.svh"

module menu_ctrl import instr_pkg::*; (
    input  logic        clk_50M,
    input  logic        rst_n,
    input  key_events_t keys,
    output instr_mode_t mode,
    output logic [1:0]  menu_cursor
);
    localparam logic [1:0] cursor_last = 2'(`menu_items - 1);

    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            mode        <= mode_menu;
            menu_cursor <= 2'd0;
        end else begin
            unique case (mode)
                mode_menu: begin
                    if (keys.left) begin
                        if (menu_cursor == 2'd0) begin
                            menu_cursor <= cursor_last;
                        end else begin
                            menu_cursor <= menu_cursor - 2'd1;
                        end
                    end else if (keys.right) begin
                        if (menu_cursor >= cursor_last) begin
                            menu_cursor <= 2'd0;
                        end else begin
                            menu_cursor <= menu_cursor + 2'd1;
                        end
                    end else if (keys.confirm) begin
                        // cursor picks the tool
                        case (menu_cursor)
                            2'd0: begin
                                mode <= mode_sig;
                            end
                            2'd1: begin
                                mode <= mode_osc;
                            end
                            2'd2: begin
                                mode <= mode_la;
                            end
                            default: begin
                                mode <= mode_menu;
                            end
                        endcase
                    end
                end
                mode_sig, mode_osc, mode_la: begin
                    // only quit matters inside a tool
                    if (keys.quit) begin
                        mode        <= mode_menu;
                        menu_cursor <= 2'd0;
                    end
                end
                default: begin
                    mode        <= mode_menu;
                    menu_cursor <= 2'd0;
                end
            endcase
        end
    end

endmodule

/* hw/osc_panel.sv */
`timescale 1ns/1ps
`include "instr_params.svh"

module osc_panel import instr_pkg::*; (
    input  logic          clk_50M,
    input  logic          rst_n,
    input  key_events_t   keys,
    input  instr_mode_t   mode,
    output osc_settings_t settings
);
    localparam logic [1:0] zoom_top = 2'(`zoom_max);

    logic active;

    // zoom step with wrap in 0..zoom_max
    function automatic logic [1:0] step_zoom(
        input logic [1:0] value,
        input logic       inc,
        input logic       dec
    );
        logic [1:0] next;
        next = value;
        if (inc) begin
            next = (value >= zoom_top) ? 2'd0 : value + 2'd1;
        end else if (dec) begin
            next = (value == 2'd0) ? zoom_top : value - 2'd1;
        end
        return next;
    endfunction

    assign active = (mode == mode_osc) && !keys.quit;

    always_ff @(posedge clk_50M) begin
        if (!rst_n || !active) begin
            settings <= '0;
        end else begin
            if (keys.confirm) begin
                settings.fft_run <= 1'b1;
            end
            // zooms freeze once fft is running
            if (!settings.fft_run) begin
                settings.v_zoom <= step_zoom(settings.v_zoom, keys.up, keys.down);
                settings.h_zoom <= step_zoom(settings.h_zoom, keys.right, keys.left);
            end
        end
    end

endmodule

/* hw/sig_panel.sv */
`timescale 1ns/1ps
`include "instr_params.svh"

module sig_panel import instr_pkg::*; (
    input  logic          clk_50M,
    input  logic          rst_n,
    input  key_events_t   keys,
    input  instr_mode_t   mode,
    output sig_settings_t settings
);
    localparam sig_field_t last_field = sig_field_t'(`sig_field_count - 1);
    localparam logic [1:0] top_value  = 2'(`setting_max);

    logic       active;
    logic [1:0] stepped;
    logic [1:0] selected;

    // left steps down, right steps up, both wrap
    function automatic logic [1:0] step_setting(
        input logic [1:0] value,
        input logic       dec,
        input logic       inc
    );
        logic [1:0] next;
        next = value;
        if (dec) begin
            next = (value == 2'd0) ? top_value : value - 2'd1;
        end else if (inc) begin
            next = (value == top_value) ? 2'd0 : value + 2'd1;
        end
        return next;
    endfunction

    assign active = (mode == mode_sig) && !keys.quit;

    always_comb begin
        case (settings.field)
            field_wave:  selected = settings.wave;
            field_amp:   selected = settings.amp;
            field_freq:  selected = settings.freq;
            field_phase: selected = settings.phase;
            default:     selected = 2'd0;
        endcase
    end

    assign stepped = step_setting(selected, keys.left, keys.right);

    always_ff @(posedge clk_50M) begin
        if (!rst_n || !active) begin
            settings <= '0;
        end else begin
            if (keys.up) begin
                if (settings.field == field_wave) begin
                    settings.field <= last_field;
                end else begin
                    settings.field <= sig_field_t'(settings.field - 3'd1);
                end
            end else if (keys.down) begin
                if (settings.field == last_field) begin
                    settings.field <= field_wave;
                end else begin
                    settings.field <= sig_field_t'(settings.field + 3'd1);
                end
            end

            case (settings.field)
                field_wave:  settings.wave  <= stepped;
                field_amp:   settings.amp   <= stepped;
                field_freq:  settings.freq  <= stepped;
                field_phase: settings.phase <= stepped;
                default: begin
                    // apply position, confirm latches it
                    if (keys.confirm) begin
                        settings.applied <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

/* tb.f */
+incdir+hw
hw/instr_pkg.sv
hw/key_debounce.sv
hw/menu_ctrl.sv
hw/sig_panel.sv
hw/osc_panel.sv
hw/la_panel.sv
hw/instr_ui_top.sv
verif/instr_ui_properties.sv
verif/instr_ui_tb.sv

/* verif/instr_ui_properties.sv */
`timescale 1ns/1ps
`include "instr_params.svh"

module instr_ui_properties import instr_pkg::*; (
    input logic          clk_50M,
    input logic          rst_n,
    input key_events_t   keys,
    input instr_mode_t   mode,
    input sig_settings_t sig_settings,
    input osc_settings_t osc_settings,
    input la_settings_t  la_settings
);
    // a tool is entered only by confirm
    enter_needs_confirm: assert property (@(posedge clk_50M) disable iff (!rst_n)
        ($past(mode) == mode_menu && mode != mode_menu) |-> $past(keys.confirm))
        else $error("mode left the menu without a confirm pulse");

    idle_panels_zero: assert property (@(posedge clk_50M) disable iff (!rst_n)
        (mode == mode_sig || sig_settings == '0) && (mode == mode_osc || osc_settings == '0))
        else $error("sig or osc settings nonzero outside their mode");

    marker_on_grid: assert property (@(posedge clk_50M) disable iff (!rst_n)
        int'(la_settings.marker) >= `marker_step && int'(la_settings.marker) <= `marker_max
        && int'(la_settings.marker) % `marker_step == 0)
        else $error("marker off the 80 pixel grid");

    zoom_in_range: assert property (@(posedge clk_50M) disable iff (!rst_n)
        osc_settings.v_zoom != 2'd3 && osc_settings.h_zoom != 2'd3)
        else $error("zoom step out of range");

endmodule

bind instr_ui_top instr_ui_properties u_instr_ui_properties (
    .clk_50M     (clk_50M),
    .rst_n       (rst_n),
    .keys        (keys),
    .mode        (mode),
    .sig_settings(sig_settings),
    .osc_settings(osc_settings),
    .la_settings (la_settings)
);

/* verif/instr_ui_tb.sv */
`timescale 1ns/1ps
`include "instr_params.svh"

module instr_ui_tb import instr_pkg::*; ();
    localparam int hold         = 16;
    localparam int run_limit_ns = 200000;

    localparam logic [2:0] k_left    = 3'd0;
    localparam logic [2:0] k_right   = 3'd1;
    localparam logic [2:0] k_up      = 3'd2;
    localparam logic [2:0] k_down    = 3'd3;
    localparam logic [2:0] k_confirm = 3'd4;
    localparam logic [2:0] k_quit    = 3'd5;

    // marker parked at its first position with nothing paused or scrolling
    localparam la_settings_t la_home = {12'd80, 3'b000};

    typedef struct packed {
        logic [2:0]    key;
        logic          glitch;
        instr_mode_t   mode;
        logic [1:0]    cursor;
        sig_settings_t sig;
        osc_settings_t osc;
        la_settings_t  la;
        logic          capture;
        logic [1:0]    scroll;
    } row_t;

    logic                  clk_50M;
    logic                  rst_n;
    logic [`key_count-1:0] key_in;
    instr_mode_t           mode;
    logic [1:0]            menu_cursor;
    sig_settings_t         sig_settings;
    osc_settings_t         osc_settings;
    la_settings_t          la_settings;
    logic                  la_capture_run;

    row_t table_q[$];
    int   left_cnt;
    int   right_cnt;

    instr_ui_top #(
        .hold_cycles(hold)
    ) u_instr_ui_top (
        .clk_50M       (clk_50M),
        .rst_n         (rst_n),
        .key_in        (key_in),
        .mode          (mode),
        .menu_cursor   (menu_cursor),
        .sig_settings  (sig_settings),
        .osc_settings  (osc_settings),
        .la_settings   (la_settings),
        .la_capture_run(la_capture_run)
    );

    always #10 clk_50M = ~clk_50M;

    function automatic void add_row(logic [2:0] key, logic glitch, instr_mode_t m, int cursor,
            sig_settings_t s, osc_settings_t o, la_settings_t l, logic cap, logic [1:0] scroll);
        row_t r;
        r.key     = key;
        r.glitch  = glitch;
        r.mode    = m;
        r.cursor  = 2'(cursor);
        r.sig     = s;
        r.osc     = o;
        r.la      = l;
        r.capture = cap;
        r.scroll  = scroll;
        table_q.push_back(r);
    endfunction

    // a glitch leaves every output where the row before it left them
    function automatic void add_glitch_row(logic [2:0] key);
        row_t r;
        r        = table_q[$];
        r.key    = key;
        r.glitch = 1'b1;
        r.scroll = 2'b00;
        table_q.push_back(r);
    endfunction

    function automatic void expect_menu(logic [2:0] key, logic glitch, int cursor);
        add_row(key, glitch, mode_menu, cursor, '0, '0, la_home, 1'b0, 2'b00);
    endfunction

    function automatic void expect_sig(logic [2:0] key, sig_field_t f, int w, int a, int fr,
            int p, logic ap);
        sig_settings_t s;
        s.field   = f;
        s.wave    = 2'(w);
        s.amp     = 2'(a);
        s.freq    = 2'(fr);
        s.phase   = 2'(p);
        s.applied = ap;
        add_row(key, 1'b0, mode_sig, 0, s, '0, la_home, 1'b0, 2'b00);
    endfunction

    function automatic void expect_osc(logic [2:0] key, int v, int h, logic fft);
        osc_settings_t o;
        o.v_zoom  = 2'(v);
        o.h_zoom  = 2'(h);
        o.fft_run = fft;
        add_row(key, 1'b0, mode_osc, 1, '0, o, la_home, 1'b0, 2'b00);
    endfunction

    // scroll bits {left, right} each stand for one pulse in the window
    function automatic void expect_la(logic [2:0] key, int marker, logic paused,
            logic [1:0] scroll);
        la_settings_t l;
        l.marker       = 12'(marker);
        l.paused       = paused;
        l.scroll_left  = 1'b0;
        l.scroll_right = 1'b0;
        add_row(key, 1'b0, mode_la, 2, '0, '0, l, 1'b1, scroll);
    endfunction

    function automatic void build_table();
        for (int k = 0; k < `key_count; k++) begin
            expect_menu(3'(k), 1'b1, 0);
        end
        expect_menu(k_left, 1'b0, 2);
        expect_menu(k_right, 1'b0, 0);
        expect_menu(k_right, 1'b0, 1);
        expect_menu(k_right, 1'b0, 2);
        expect_menu(k_right, 1'b0, 0);
        expect_sig(k_confirm, field_wave, 0, 0, 0, 0, 1'b0);
        add_glitch_row(k_up);
        add_glitch_row(k_down);
        add_glitch_row(k_quit);
        expect_sig(k_left, field_wave, 3, 0, 0, 0, 1'b0);
        expect_sig(k_right, field_wave, 0, 0, 0, 0, 1'b0);
        expect_sig(k_confirm, field_wave, 0, 0, 0, 0, 1'b0);
        expect_sig(k_up, field_apply, 0, 0, 0, 0, 1'b0);
        expect_sig(k_left, field_apply, 0, 0, 0, 0, 1'b0);
        expect_sig(k_confirm, field_apply, 0, 0, 0, 0, 1'b1);
        expect_sig(k_down, field_wave, 0, 0, 0, 0, 1'b1);
        expect_sig(k_down, field_amp, 0, 0, 0, 0, 1'b1);
        expect_sig(k_left, field_amp, 0, 3, 0, 0, 1'b1);
        expect_sig(k_down, field_freq, 0, 3, 0, 0, 1'b1);
        expect_sig(k_right, field_freq, 0, 3, 1, 0, 1'b1);
        expect_sig(k_down, field_phase, 0, 3, 1, 0, 1'b1);
        expect_sig(k_left, field_phase, 0, 3, 1, 3, 1'b1);
        expect_sig(k_up, field_freq, 0, 3, 1, 3, 1'b1);
        expect_menu(k_quit, 1'b0, 0);
        expect_menu(k_right, 1'b0, 1);
        expect_osc(k_confirm, 0, 0, 1'b0);
        expect_osc(k_up, 1, 0, 1'b0);
        expect_osc(k_up, 2, 0, 1'b0);
        expect_osc(k_up, 0, 0, 1'b0);
        expect_osc(k_down, 2, 0, 1'b0);
        expect_osc(k_left, 2, 2, 1'b0);
        expect_osc(k_right, 2, 0, 1'b0);
        expect_osc(k_right, 2, 1, 1'b0);
        expect_osc(k_confirm, 2, 1, 1'b1);
        expect_osc(k_up, 2, 1, 1'b1);
        expect_osc(k_left, 2, 1, 1'b1);
        expect_menu(k_quit, 1'b0, 0);
        expect_menu(k_left, 1'b0, 2);
        expect_la(k_confirm, 80, 1'b0, 2'b00);
        expect_la(k_left, 1440, 1'b0, 2'b00);
        expect_la(k_right, 80, 1'b0, 2'b00);
        expect_la(k_right, 160, 1'b0, 2'b00);
        expect_la(k_up, 160, 1'b0, 2'b00);
        expect_la(k_confirm, 160, 1'b1, 2'b00);
        expect_la(k_up, 160, 1'b1, 2'b10);
        expect_la(k_down, 160, 1'b1, 2'b01);
        expect_la(k_right, 240, 1'b1, 2'b00);
        expect_la(k_confirm, 240, 1'b0, 2'b00);
        expect_la(k_down, 240, 1'b0, 2'b00);
        expect_menu(k_quit, 1'b0, 0);
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic value_error(input string name, input int idx, input logic [31:0] got,
            input logic [31:0] exp);
        stop_run($sformatf("ERROR row %0d %s got 0x%0h expected 0x%0h",
            idx, name, got, exp));
    endtask

    // a glitch stays well below the hold count
    task automatic press_key(input logic [2:0] k, input logic glitch);
        int width;
        if (glitch) begin
            width = int'($urandom_range(12, 1));
        end else begin
            width = hold + 4 + int'($urandom_range(7, 0));
        end
        @(negedge clk_50M);
        key_in[k] = 1'b0;
        repeat (width) @(negedge clk_50M);
        key_in[k] = 1'b1;
    endtask

    task automatic idle_and_watch(output int lc, output int rc);
        lc = 0;
        rc = 0;
        for (int n = 0; n < hold + 8; n++) begin
            @(negedge clk_50M);
            if (la_settings.scroll_left) begin
                lc++;
            end
            if (la_settings.scroll_right) begin
                rc++;
            end
        end
    endtask

    task automatic check_row(input int idx, input row_t r, input int lc, input int rc);
        assert (mode === r.mode)
            else value_error("mode", idx, 32'(mode), 32'(r.mode));
        assert (menu_cursor === r.cursor)
            else value_error("menu_cursor", idx, 32'(menu_cursor), 32'(r.cursor));
        assert (sig_settings === r.sig)
            else value_error("sig_settings", idx, 32'(sig_settings), 32'(r.sig));
        assert (osc_settings === r.osc)
            else value_error("osc_settings", idx, 32'(osc_settings), 32'(r.osc));
        assert (la_settings === r.la)
            else value_error("la_settings", idx, 32'(la_settings), 32'(r.la));
        assert (la_capture_run === r.capture)
            else value_error("la_capture_run", idx, 32'(la_capture_run), 32'(r.capture));
        assert (lc == int'(r.scroll[1]))
            else value_error("la_settings.scroll_left pulses", idx, 32'(lc), 32'(r.scroll[1]));
        assert (rc == int'(r.scroll[0]))
            else value_error("la_settings.scroll_right pulses", idx, 32'(rc), 32'(r.scroll[0]));
    endtask

    initial begin
        #(run_limit_ns);
        stop_run("timeout: the run did not finish within its time limit");
    end

    initial begin
        clk_50M = 1'b0;
        rst_n   = 1'b0;
        key_in  = '1;
        void'($urandom(32'h8c81));
        build_table();
        repeat (8) @(negedge clk_50M);
        rst_n = 1'b1;
        // first row is a glitch and so expects the reset state
        idle_and_watch(left_cnt, right_cnt);
        check_row(0, table_q[0], left_cnt, right_cnt);
        foreach (table_q[i]) begin
            press_key(table_q[i].key, table_q[i].glitch);
            idle_and_watch(left_cnt, right_cnt);
            check_row(i + 1, table_q[i], left_cnt, right_cnt);
        end
        $display(">>> PASS");
        $finish;
    end

endmodule
